// ==== rtl/avmm_cfg.svh ====
// Size and threshold settings for the Avalon clock-crossing shim
`ifndef AVMM_CFG_SVH
`define AVMM_CFG_SVH

// Word address width, so one address step is one data word
`define AVMM_ADDR_W 16

// Data path width and the byte enables that go with it
`define AVMM_DATA_W 32
`define AVMM_BE_W (`AVMM_DATA_W / 8)

// Burstcount field width, which allows bursts of up to 15 beats
`define AVMM_BURST_W 4

// FIFO depths, all powers of two because the pointers are Gray coded
`define AVMM_CMD_DEPTH 16
`define AVMM_RSP_DEPTH 32
`define AVMM_WRSP_DEPTH 16

// Zero gives plain waitrequest
// A nonzero value N lets the host issue N requests after waitrequest rises
`define AVMM_CMD_ALMFULL_THRESHOLD 4

`endif

// ==== rtl/avmm_pkg.sv ====
// Avalon command, read-data and response types shared by the shim and its bench
`default_nettype none
`include "avmm_cfg.svh"

package avmm_pkg;

    // Two-bit Avalon response code, returned with read beats and write responses
    typedef enum logic [1:0] {
        AVMM_RESP_OKAY      = 2'b00,
        AVMM_RESP_RESERVED  = 2'b01,
        AVMM_RESP_SLVERR    = 2'b10,
        AVMM_RESP_DECODEERR = 2'b11
    } avmm_resp_t;

    // One command word as the host presents it
    // A request is present when read or write is set
    // Every beat of a write burst is its own command word
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [`AVMM_ADDR_W-1:0]  address;
        logic [`AVMM_BURST_W-1:0] burstcount;
        logic [`AVMM_BE_W-1:0]    byteenable;
        logic [`AVMM_DATA_W-1:0]  writedata;
    } avmm_cmd_t;

    // One read beat, with the response kept next to its data
    typedef struct packed {
        avmm_resp_t              response;
        logic [`AVMM_DATA_W-1:0] readdata;
    } avmm_rdata_t;

endpackage

`default_nettype wire

// ==== rtl/dc_fifo.sv ====
// Dual-clock FIFO that carries a typed payload across two clock domains
`timescale 1ns/1ps
`default_nettype none

module dc_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 16
) (
    input  wire                      wr_clk,
    input  wire                      wr_rst_n,
    input  wire                      wr_en,
    input  wire T                    wr_data,
    output logic [$clog2(DEPTH):0]   wr_space,
    input  wire                      rd_clk,
    input  wire                      rd_rst_n,
    input  wire                      rd_en,
    output T                         rd_data,
    output logic                     rd_empty
);

    // Pointers carry one extra bit so that full and empty can be told apart
    localparam int AW = $clog2(DEPTH);
    localparam int PW = AW + 1;

    // Turns a synchronized Gray pointer back into a binary count
    function automatic logic [PW-1:0] gray2bin(input logic [PW-1:0] g);
        logic [PW-1:0] b;
        b[PW-1] = g[PW-1];
        for (int i = PW - 2; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    T mem [DEPTH];

    logic [PW-1:0] wr_bin;
    logic [PW-1:0] wr_bin_next;
    logic [PW-1:0] wr_gray;
    logic [PW-1:0] rd_gray_meta;
    logic [PW-1:0] rd_gray_sync;
    logic [PW-1:0] rd_bin_sync;
    logic          wr_ok;

    logic [PW-1:0] rd_bin;
    logic [PW-1:0] rd_bin_next;
    logic [PW-1:0] rd_gray;
    logic [PW-1:0] wr_gray_meta;
    logic [PW-1:0] wr_gray_sync;
    logic          rd_ok;

    // Free space is counted against a read pointer that lags, so it never overstates room
    assign rd_bin_sync = gray2bin(rd_gray_sync);
    assign wr_space    = PW'(DEPTH) - (wr_bin - rd_bin_sync);
    // A write into a full FIFO is dropped rather than overwriting the oldest entry
    assign wr_ok       = wr_en && (wr_space != '0);
    assign wr_bin_next = wr_bin + PW'(wr_ok);

    always_ff @(posedge wr_clk)
    begin
        if (!wr_rst_n)
        begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end
        else
        begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= wr_bin_next ^ (wr_bin_next >> 1);
            // Two flops bring the read pointer into the write domain
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    // Storage is written on the write clock and carries no reset
    always_ff @(posedge wr_clk)
    begin
        if (wr_ok)
        begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    // The head word is shown as soon as the synchronized write pointer moves past it
    assign rd_empty    = (rd_gray == wr_gray_sync);
    assign rd_data     = mem[rd_bin[AW-1:0]];
    // Holding rd_en while empty leaves the pointer where it is
    assign rd_ok       = rd_en && !rd_empty;
    assign rd_bin_next = rd_bin + PW'(rd_ok);

    always_ff @(posedge rd_clk)
    begin
        if (!rd_rst_n)
        begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end
        else
        begin
            rd_bin       <= rd_bin_next;
            rd_gray      <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/avmm_cross_bridge.sv ====
// Avalon command and read-response clock crossing with read-credit accounting
`timescale 1ns/1ps
`default_nettype none
`include "avmm_cfg.svh"

module avmm_cross_bridge (
    input  wire                                mem_master,
    input  wire                                rst_n,
    input  wire                                mem_slave,
    input  wire                                slave_rst_n,
    input  wire avmm_pkg::avmm_cmd_t           host_cmd,
    input  wire                                cmd_accept,
    output logic                               cmd_blocked,
    output logic [$clog2(`AVMM_CMD_DEPTH):0]   cmd_space,
    output avmm_pkg::avmm_rdata_t              host_rdata,
    output logic                               host_rdata_valid,
    output avmm_pkg::avmm_cmd_t                mem_cmd,
    input  wire                                mem_waitrequest,
    input  wire avmm_pkg::avmm_rdata_t         mem_rdata,
    input  wire                                mem_rdata_valid
);
    import avmm_pkg::*;

    // The credit counter must be able to hold the full response depth
    localparam int CRED_W = $clog2(`AVMM_RSP_DEPTH) + 1;

    logic [CRED_W-1:0] rd_credits;
    logic [CRED_W-1:0] burst_need;
    logic              read_taken;
    logic              credit_short;
    avmm_cmd_t         cmd_head;
    logic              cmd_empty;
    logic              cmd_pop;
    logic              rsp_empty;

    // A read reserves one response slot per beat before it is accepted
    assign burst_need   = CRED_W'(host_cmd.burstcount);
    assign credit_short = host_cmd.read && (rd_credits < burst_need);
    assign cmd_blocked  = (cmd_space == '0) || credit_short;
    assign read_taken   = cmd_accept && host_cmd.read;

    // Each delivered beat frees its slot again, so both can happen in one cycle
    always_ff @(posedge mem_master)
    begin
        if (!rst_n)
        begin
            rd_credits <= CRED_W'(`AVMM_RSP_DEPTH);
        end
        else
        begin
            rd_credits <= rd_credits - (read_taken ? burst_need : '0)
                          + CRED_W'(host_rdata_valid);
        end
    end

    // Commands cross from the host clock to the memory clock
    dc_fifo #(
        .T     (avmm_cmd_t),
        .DEPTH (`AVMM_CMD_DEPTH)
    ) cmd_fifo (
        .wr_clk   (mem_master),
        .wr_rst_n (rst_n),
        .wr_en    (cmd_accept),
        .wr_data  (host_cmd),
        .wr_space (cmd_space),
        .rd_clk   (mem_slave),
        .rd_rst_n (slave_rst_n),
        .rd_en    (cmd_pop),
        .rd_data  (cmd_head),
        .rd_empty (cmd_empty)
    )
    ;

    // The head word stays on mem_cmd until the memory drops waitrequest
    assign cmd_pop = !cmd_empty && !mem_waitrequest;

    always_comb
    begin
        mem_cmd       = cmd_head;
        mem_cmd.read  = cmd_head.read && !cmd_empty;
        mem_cmd.write = cmd_head.write && !cmd_empty;
    end

    // Read beats cross back, and the credits guarantee there is always room for them
    dc_fifo #(
        .T     (avmm_rdata_t),
        .DEPTH (`AVMM_RSP_DEPTH)
    ) rsp_fifo (
        .wr_clk   (mem_slave),
        .wr_rst_n (slave_rst_n),
        .wr_en    (mem_rdata_valid),
        .wr_data  (mem_rdata),
        .wr_space (),
        .rd_clk   (mem_master),
        .rd_rst_n (rst_n),
        .rd_en    (1'b1),
        .rd_data  (host_rdata),
        .rd_empty (rsp_empty)
    );

    // The host never stalls read data, so each queued beat is shown for one cycle
    assign host_rdata_valid = !rsp_empty;

endmodule

`default_nettype wire

// ==== rtl/avmm_async_shim.sv ====
// Avalon clock-crossing shim with write responses and selectable waitrequest mode
`timescale 1ns/1ps
`default_nettype none
`include "avmm_cfg.svh"

module avmm_async_shim (
    input  wire                          mem_master,
    input  wire                          mem_slave,
    input  wire                          rst_n,
    input  wire avmm_pkg::avmm_cmd_t     host_cmd,
    output logic                         host_waitrequest,
    output avmm_pkg::avmm_rdata_t        host_rdata,
    output logic                         host_rdata_valid,
    output avmm_pkg::avmm_resp_t         host_wresp,
    output logic                         host_wresp_valid,
    output avmm_pkg::avmm_cmd_t          mem_cmd,
    input  wire                          mem_waitrequest,
    input  wire avmm_pkg::avmm_rdata_t   mem_rdata,
    input  wire                          mem_rdata_valid,
    input  wire avmm_pkg::avmm_resp_t    mem_wresp,
    input  wire                          mem_wresp_valid
);
    import avmm_pkg::*;

    localparam int CMD_SW = $clog2(`AVMM_CMD_DEPTH) + 1;

    logic [1:0]        slave_rst_pipe;
    logic              slave_rst_n;
    logic              host_req;
    logic              cmd_accept;
    logic              cmd_blocked;
    logic [CMD_SW-1:0] cmd_space;
    avmm_resp_t        wrsp_head;
    logic              wrsp_empty;

    // Two flops carry the host reset into the memory clock domain
    always_ff @(posedge mem_slave)
    begin
        slave_rst_pipe <= {slave_rst_pipe[0], rst_n};
    end

    assign slave_rst_n = slave_rst_pipe[1];
    assign host_req    = host_cmd.read || host_cmd.write;

    avmm_cross_bridge bridge (
        .mem_master       (mem_master),
        .rst_n            (rst_n),
        .mem_slave        (mem_slave),
        .slave_rst_n      (slave_rst_n),
        .host_cmd         (host_cmd),
        .cmd_accept       (cmd_accept),
        .cmd_blocked      (cmd_blocked),
        .cmd_space        (cmd_space),
        .host_rdata       (host_rdata),
        .host_rdata_valid (host_rdata_valid),
        .mem_cmd          (mem_cmd),
        .mem_waitrequest  (mem_waitrequest),
        .mem_rdata        (mem_rdata),
        .mem_rdata_valid  (mem_rdata_valid)
    );

    // Write responses are narrow and the memory bounds writes in flight, so no space check
    dc_fifo #(
        .T     (avmm_resp_t),
        .DEPTH (`AVMM_WRSP_DEPTH)
    ) wrsp_fifo (
        .wr_clk   (mem_slave),
        .wr_rst_n (slave_rst_n),
        .wr_en    (mem_wresp_valid),
        .wr_data  (mem_wresp),
        .wr_space (),
        .rd_clk   (mem_master),
        .rd_rst_n (rst_n),
        .rd_en    (1'b1),
        .rd_data  (wrsp_head),
        .rd_empty (wrsp_empty)
    );

    // The response code is registered so it lines up with its valid strobe
    always_ff @(posedge mem_master)
    begin
        host_wresp       <= wrsp_head;
        host_wresp_valid <= !wrsp_empty && rst_n;
    end

    generate
        if (`AVMM_CMD_ALMFULL_THRESHOLD == 0)
        begin : g_plain
            // Ordinary Avalon waitrequest straight from the bridge
            assign host_waitrequest = cmd_blocked;
            assign cmd_accept       = host_req && !host_waitrequest;
        end
        else
        begin : g_almfull
            logic [CMD_SW-1:0] space_after;
            logic              waitreq_q;

            // Space left once this cycle's request has gone in
            assign space_after = cmd_space - CMD_SW'(cmd_accept);

            // Rising at the threshold leaves room for the requests that follow it
            always_ff @(posedge mem_master)
            begin
                if (!rst_n)
                begin
                    waitreq_q <= 1'b1;
                end
                else
                begin
                    waitreq_q <= cmd_blocked ||
                        (space_after <= CMD_SW'(`AVMM_CMD_ALMFULL_THRESHOLD));
                end
            end

            assign host_waitrequest = waitreq_q;
            // Requests in the allowance still go in while the bridge has room and credits
            assign cmd_accept       = host_req && !cmd_blocked;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
// Free-running clock source for the testbench with a settable period
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // Starts low so the first rising edge lands half a period in
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== bench/avmm_async_shim_checker.sv ====
// Assertions on the bridge's command acceptance and read-credit accounting
`timescale 1ns/1ps
`default_nettype none
`include "avmm_cfg.svh"

module avmm_async_shim_checker (
    input wire                                mem_master,
    input wire                                rst_n,
    input wire                                cmd_accept,
    input wire [$clog2(`AVMM_CMD_DEPTH):0]    cmd_space,
    input wire [$clog2(`AVMM_RSP_DEPTH):0]    rd_credits,
    input wire                                host_rdata_valid
);

    // A full command FIFO must never be written
    no_write_when_full: assert property (@(posedge mem_master) disable iff (!rst_n)
        cmd_accept |-> (cmd_space != '0))
        else $error("command accepted while the command FIFO was full");

    // Credits count free response slots and cannot exceed the FIFO depth
    credits_bounded: assert property (@(posedge mem_master) disable iff (!rst_n)
        rd_credits <= ($clog2(`AVMM_RSP_DEPTH) + 1)'(`AVMM_RSP_DEPTH))
        else $error("read credit count rose above the response FIFO depth");

    // A returned beat needs a read beat outstanding, which shows as a missing credit
    no_stray_beat: assert property (@(posedge mem_master) disable iff (!rst_n)
        host_rdata_valid |-> (rd_credits < ($clog2(`AVMM_RSP_DEPTH) + 1)'(`AVMM_RSP_DEPTH)))
        else $error("read data delivered with no read beat outstanding");

endmodule

bind avmm_cross_bridge avmm_async_shim_checker bridge_chk (
    .mem_master       (mem_master),
    .rst_n            (rst_n),
    .cmd_accept       (cmd_accept),
    .cmd_space        (cmd_space),
    .rd_credits       (rd_credits),
    .host_rdata_valid (host_rdata_valid)
);

`default_nettype wire

// ==== bench/avmm_async_shim_tb.sv ====
// Testbench for the Avalon clock-crossing shim with a slave memory model and scoreboard
`timescale 1ns/1ps
`default_nettype none
`include "avmm_cfg.svh"

module avmm_async_shim_tb;
    import avmm_pkg::*;

    localparam int ALLOW     = `AVMM_CMD_ALMFULL_THRESHOLD;
    localparam int RSP_SLOTS = `AVMM_RSP_DEPTH;
    localparam int WR_LIMIT  = 8;
    localparam int TIMEOUT   = 20000;
    localparam int WORDS     = 1 << `AVMM_ADDR_W;
    localparam logic [`AVMM_ADDR_W-1:0] ERR_BASE = 16'hF000;

    wire                     mem_master;
    wire                     mem_slave;
    logic                    rst_n;
    avmm_cmd_t               host_cmd;
    logic                    host_waitrequest;
    avmm_rdata_t             host_rdata;
    logic                    host_rdata_valid;
    avmm_resp_t              host_wresp;
    logic                    host_wresp_valid;
    avmm_cmd_t               mem_cmd;
    logic                    mem_waitrequest;
    avmm_rdata_t             mem_rdata;
    logic                    mem_rdata_valid;
    avmm_resp_t              mem_wresp;
    logic                    mem_wresp_valid;

    // Memory model storage and the host's own copy of what it should hold
    logic [`AVMM_DATA_W-1:0] mem_words [WORDS];
    logic [`AVMM_DATA_W-1:0] shadow [WORDS];
    avmm_rdata_t             beat_pend [$];
    avmm_resp_t              wresp_pend [$];
    logic [`AVMM_ADDR_W-1:0] model_addr;
    avmm_rdata_t             model_beat;
    // Read beats and write commands as the memory actually received them
    int                      mem_rd_beats;
    int                      mem_wr_cmds;

    // Scoreboard state shared by the host and compare processes
    avmm_rdata_t             rd_exp [$];
    avmm_resp_t              wr_exp [$];
    avmm_rdata_t             rd_want;
    avmm_resp_t              wr_want;
    int                      rd_issued;
    int                      wr_issued;
    int                      rd_seen;
    int                      wr_seen;
    int                      allow_left;
    int                      allow_used;
    int                      stall_level;
    integer                  seed;
    string                   test_name;

    tb_clock #(.PERIOD(100)) master_clk (.clk(mem_master));
    tb_clock #(.PERIOD(70))  slave_clk  (.clk(mem_slave));

    avmm_async_shim UUT (
        .mem_master       (mem_master),
        .mem_slave        (mem_slave),
        .rst_n            (rst_n),
        .host_cmd         (host_cmd),
        .host_waitrequest (host_waitrequest),
        .host_rdata       (host_rdata),
        .host_rdata_valid (host_rdata_valid),
        .host_wresp       (host_wresp),
        .host_wresp_valid (host_wresp_valid),
        .mem_cmd          (mem_cmd),
        .mem_waitrequest  (mem_waitrequest),
        .mem_rdata        (mem_rdata),
        .mem_rdata_valid  (mem_rdata_valid),
        .mem_wresp        (mem_wresp),
        .mem_wresp_valid  (mem_wresp_valid)
    );

    // Expected read beat is the shadow word, with slave error from the top of the map upward
    function automatic avmm_rdata_t expect_read(input logic [`AVMM_ADDR_W-1:0] addr);
        avmm_rdata_t r;
        r.readdata = shadow[addr];
        r.response = (addr >= ERR_BASE) ? AVMM_RESP_SLVERR : AVMM_RESP_OKAY;
        return r;
    endfunction

    // Writes in the error region are dropped and answered with slave error
    function automatic avmm_resp_t expect_wresp(input logic [`AVMM_ADDR_W-1:0] addr);
        return (addr >= ERR_BASE) ? AVMM_RESP_SLVERR : AVMM_RESP_OKAY;
    endfunction

    task automatic abort_test(input string what);
        $display("ERROR in %s: %s", test_name, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input avmm_rdata_t exp, input avmm_rdata_t act);
        if (act !== exp)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_wresp(input string name, input avmm_resp_t exp, input avmm_resp_t act);
        if (act !== exp)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Holds a request until the shim can take it, then presents it for one cycle
    // Read credits are tracked here too, so a read is never refused for lack of room
    task automatic send_cmd(input avmm_cmd_t c);
        int waited;
        int need;
        waited = 0;
        need   = c.read ? int'(c.burstcount) : 0;
        while ((host_waitrequest !== 1'b0 && allow_left == 0) ||
               (rd_exp.size() + need > RSP_SLOTS) ||
               (c.write && wr_exp.size() >= WR_LIMIT))
        begin
            @(posedge mem_master);
            #5;
            waited++;
            if (waited > TIMEOUT)
            begin
                abort_test("the shim never took the pending request");
            end
        end
        // Requests after waitrequest rises spend the almost-full allowance
        if (host_waitrequest === 1'b1)
        begin
            allow_left--;
            allow_used++;
        end
        else
        begin
            allow_left = ALLOW;
        end
        if (c.read)
        begin
            for (int i = 0; i < need; i++)
            begin
                rd_exp.push_back(expect_read(c.address + `AVMM_ADDR_W'(i)));
                rd_issued++;
            end
        end
        else
        begin
            if (c.address < ERR_BASE)
            begin
                for (int b = 0; b < `AVMM_BE_W; b++)
                begin
                    if (c.byteenable[b])
                    begin
                        shadow[c.address][8*b +: 8] = c.writedata[8*b +: 8];
                    end
                end
            end
            wr_exp.push_back(expect_wresp(c.address));
            wr_issued++;
        end
        host_cmd = c;
        @(posedge mem_master);
        #5;
        host_cmd = '0;
    endtask

    task automatic issue_write(input logic [`AVMM_ADDR_W-1:0] addr,
                               input logic [`AVMM_DATA_W-1:0] data,
                               input logic [`AVMM_BE_W-1:0] be);
        avmm_cmd_t c;
        c            = '0;
        c.write      = 1'b1;
        c.address    = addr;
        c.burstcount = 1;
        c.byteenable = be;
        c.writedata  = data;
        send_cmd(c);
    endtask

    task automatic issue_read(input logic [`AVMM_ADDR_W-1:0] addr, input int len);
        avmm_cmd_t c;
        c            = '0;
        c.read       = 1'b1;
        c.address    = addr;
        c.burstcount = `AVMM_BURST_W'(len);
        c.byteenable = '1;
        send_cmd(c);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rd_exp.size() != 0 || wr_exp.size() != 0)
        begin
            @(posedge mem_master);
            #5;
            waited++;
            if (waited > TIMEOUT)
            begin
                abort_test("outstanding reads or write responses never came back");
            end
        end
    endtask

    // The memory model accepts on the edge and drives its outputs shortly after
    always @(posedge mem_slave)
    begin
        if (mem_cmd.read === 1'b1 && mem_waitrequest === 1'b0)
        begin
            for (int i = 0; i < int'(mem_cmd.burstcount); i++)
            begin
                model_addr          = mem_cmd.address + `AVMM_ADDR_W'(i);
                model_beat.readdata = mem_words[model_addr];
                model_beat.response = (model_addr >= ERR_BASE) ? AVMM_RESP_SLVERR
                                                               : AVMM_RESP_OKAY;
                beat_pend.push_back(model_beat);
                mem_rd_beats++;
            end
        end
        // Only single-beat writes are issued, so every write command gets its response
        if (mem_cmd.write === 1'b1 && mem_waitrequest === 1'b0)
        begin
            mem_wr_cmds++;
            if (mem_cmd.address < ERR_BASE)
            begin
                for (int b = 0; b < `AVMM_BE_W; b++)
                begin
                    if (mem_cmd.byteenable[b])
                    begin
                        mem_words[mem_cmd.address][8*b +: 8] = mem_cmd.writedata[8*b +: 8];
                    end
                end
                wresp_pend.push_back(AVMM_RESP_OKAY);
            end
            else
            begin
                wresp_pend.push_back(AVMM_RESP_SLVERR);
            end
        end
        #5;
        mem_waitrequest = (($random(seed) & 3) < stall_level);
        mem_rdata_valid = (beat_pend.size() != 0) && $random(seed) % 2 == 0;
        if (mem_rdata_valid)
        begin
            mem_rdata = beat_pend.pop_front();
        end
        mem_wresp_valid = (wresp_pend.size() != 0) && $random(seed) % 2 == 0;
        if (mem_wresp_valid)
        begin
            mem_wresp = wresp_pend.pop_front();
        end
    end

    // Every valid strobe must match the oldest expected result
    always @(posedge mem_master)
    begin
        if (host_rdata_valid === 1'b1)
        begin
            if (rd_exp.size() == 0)
            begin
                abort_test("read data arrived with no read outstanding");
            end
            else
            begin
                rd_want = rd_exp.pop_front();
                check_rdata(test_name, rd_want, host_rdata);
                rd_seen++;
            end
        end
        if (host_wresp_valid === 1'b1)
        begin
            if (wr_exp.size() == 0)
            begin
                abort_test("write response arrived with no write outstanding");
            end
            else
            begin
                wr_want = wr_exp.pop_front();
                check_wresp(test_name, wr_want, host_wresp);
                wr_seen++;
            end
        end
    end

    initial
    begin
        logic [31:0] r;
        host_cmd        = '0;
        rst_n           = 1'b0;
        mem_waitrequest = 1'b1;
        mem_rdata       = '0;
        mem_rdata_valid = 1'b0;
        mem_wresp       = AVMM_RESP_OKAY;
        mem_wresp_valid = 1'b0;
        seed            = 73;
        stall_level     = 1;
        rd_issued       = 0;
        wr_issued       = 0;
        rd_seen         = 0;
        wr_seen         = 0;
        mem_rd_beats    = 0;
        mem_wr_cmds     = 0;
        allow_left      = 0;
        allow_used      = 0;
        // Model and shadow start from one fill pattern that depends on the whole address
        for (int a = 0; a < WORDS; a++)
        begin
            mem_words[a] = {a[15:0] ^ 16'hA5C3, a[7:0], a[15:8]};
            shadow[a]    = mem_words[a];
        end

        // Waitrequest stays high and both strobes stay low while in reset
        test_name = "reset";
        for (int c = 0; c < 16; c++)
        begin
            @(posedge mem_master);
            #5;
            if (c >= 1 && host_waitrequest !== 1'b1)
            begin
                abort_test("host_waitrequest was low during reset");
            end
            if (c >= 1 && (host_rdata_valid !== 1'b0 || host_wresp_valid !== 1'b0))
            begin
                abort_test("a valid strobe was high during reset");
            end
        end
        rst_n = 1'b1;

        test_name = "write_then_read";
        for (int i = 0; i < 8; i++)
        begin
            issue_write(16'h0100 + 16'(i), $random(seed), (i == 3) ? 4'b0101 : 4'hF);
        end
        for (int i = 0; i < 8; i++)
        begin
            issue_read(16'h0100 + 16'(i), 1);
        end
        wait_drain();

        test_name = "burst_reads";
        for (int len = 1; len <= 8; len++)
        begin
            issue_read(16'h2000 + 16'(len * 16), len);
        end
        wait_drain();

        // The last burst straddles the boundary into the error region
        test_name = "slave_error";
        issue_write(16'hF000, 32'hDEAD_BEEF, 4'hF);
        issue_write(16'hF123, 32'h1234_5678, 4'hF);
        issue_write(16'h0200, 32'hCAFE_F00D, 4'hF);
        issue_read(16'hF000, 2);
        issue_read(16'hEFFE, 4);
        issue_read(16'h0200, 1);
        wait_drain();

        // Heavy memory stall fills the command FIFO and brings the allowance into play
        test_name   = "back_to_back";
        stall_level = 3;
        for (int n = 0; n < 80; n++)
        begin
            r = $random(seed);
            if (r[1:0] == 2'd0)
            begin
                issue_write({(r[3:2] == 2'd3) ? 8'hF1 : 8'h30, r[11:4]}, $random(seed), 4'hF);
            end
            else
            begin
                issue_read({(r[3:2] == 2'd3) ? 8'hF1 : 8'h30, r[11:4]}, 1 + int'(r[12]));
            end
        end
        stall_level = 1;
        wait_drain();
        if (ALLOW != 0 && allow_used == 0)
        begin
            abort_test("the almost-full allowance was never used");
        end

        // A short quiet spell lets any stray strobe reach the compare process
        for (int c = 0; c < 50; c++)
        begin
            @(posedge mem_master);
        end
        if (rd_seen != rd_issued || wr_seen != wr_issued ||
            mem_rd_beats != rd_issued || mem_wr_cmds != wr_issued)
        begin
            abort_test("totals at the memory or the host differ from the issued totals");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== avmm_async_shim.f ====
+incdir+rtl
rtl/avmm_pkg.sv
rtl/dc_fifo.sv
rtl/avmm_cross_bridge.sv
rtl/avmm_async_shim.sv
bench/tb_clock.sv
bench/avmm_async_shim_checker.sv
bench/avmm_async_shim_tb.sv

// ==== Makefile ====
# Verilator build and run for the Avalon clock-crossing shim testbench

SRCS = avmm_async_shim.f $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vavmm_async_shim_tb

obj_dir/Vavmm_async_shim_tb: $(SRCS)
	verilator --binary --timing --assert --top-module avmm_async_shim_tb \
		-f avmm_async_shim.f -o Vavmm_async_shim_tb

run: obj_dir/Vavmm_async_shim_tb
	-./obj_dir/Vavmm_async_shim_tb > sim.log 2>&1
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
